// File: dv/exeRefModel.svh
/*
 * Reference model of the execute stage and the LFSR behind the random stimulus
 */
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'ha2fa_6642;

logic [31:0] lfsr;

// galois form, one step per returned bit
function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r    = {r[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
endfunction

// what decode inserts on a flush
function automatic idExeBus nopOp();
    idExeBus op;
    op        = '0;
    op.aluOp  = ADDU;
    op.branch = NONE;
    return op;
endfunction

function automatic logic [31:0] fwdVal(input logic [4:0] src, input logic [31:0] rfVal,
                                       input fwdSrc mem, input fwdSrc wb);
    if (src == 5'd0) return rfVal;                     // $zero always from the file
    if (mem.regWr && mem.dst == src) return mem.result;
    if (wb.regWr && wb.dst == src) return wb.result;
    return rfVal;
endfunction

function automatic exeMemBus modelExe(input idExeBus s, input fwdSrc mem, input fwdSrc wb,
                                      input logic [31:0] hi, input logic [31:0] lo);
    exeMemBus    r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] x;
    logic [31:0] y;
    logic [32:0] wide;
    a             = fwdVal(s.rs, s.busA, mem, wb);
    b             = fwdVal(s.rt, s.busB, mem, wb);
    x             = s.aluSrcA ? {27'd0, s.shamt} : a;
    y             = s.aluSrcB ? s.imm32 : b;
    r.storeData   = b;
    r.dst         = s.dst;
    r.excOverflow = 1'b0;
    case (s.aluOp)
        ADD, ADDU: begin
            wide     = {x[31], x} + {y[31], y};      // sign bit copy shows overflow
            r.aluOut = wide[31:0];
            if (s.aluOp == ADD) r.excOverflow = wide[32] != wide[31];
        end
        SUB, SUBU: begin
            wide     = {x[31], x} - {y[31], y};
            r.aluOut = wide[31:0];
            if (s.aluOp == SUB) r.excOverflow = wide[32] != wide[31];
        end
        AND:     r.aluOut = x & y;
        OR:      r.aluOut = x | y;
        XOR:     r.aluOut = x ^ y;
        NOR:     r.aluOut = ~(x | y);
        SLT:     r.aluOut = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        SLTU:    r.aluOut = (x < y) ? 32'd1 : 32'd0;
        SLL:     r.aluOut = y << x[4:0];
        SRL:     r.aluOut = y >> x[4:0];
        SRA:     r.aluOut = $signed(y) >>> x[4:0];
        LUI:     r.aluOut = {y[15:0], 16'h0000};
        MFHI:    r.aluOut = hi;
        MFLO:    r.aluOut = lo;
        default: r.aluOut = '0;
    endcase
    r.regWr = s.regWr && !r.excOverflow;
    return r;
endfunction

function automatic branchRes modelBranch(input idExeBus s, input fwdSrc mem, input fwdSrc wb);
    branchRes    r;
    logic [31:0] a;
    logic [31:0] b;
    a = fwdVal(s.rs, s.busA, mem, wb);
    b = fwdVal(s.rt, s.busB, mem, wb);
    case (s.branch)
        BEQ:     r.taken = a == b;
        BNE:     r.taken = a != b;
        BLEZ:    r.taken = $signed(a) <= 0;
        BGTZ:    r.taken = $signed(a) > 0;
        BLTZ:    r.taken = $signed(a) < 0;
        BGEZ:    r.taken = $signed(a) >= 0;
        JR:      r.taken = 1'b1;
        default: r.taken = 1'b0;
    endcase
    r.target = (s.branch == JR) ? a : s.pc + 32'd4 + (s.imm32 << 2);
    return r;
endfunction

// returns {hi, lo}
function automatic logic [63:0] modelMulDiv(input logic isDiv, input logic [31:0] a,
                                            input logic [31:0] b);
    if (!isDiv) return {32'd0, a} * {32'd0, b};
    if (b == '0) return {a, 32'hffff_ffff};          // quotient all ones, remainder a
    return {a % b, a / b};
endfunction

`endif

// File: dv/exeTb.sv
/*
 * Testbench for the execute stage, random ALU, bypass, branch and
 * mul/div traffic checked against a reference model
 */
`timescale 1ns/1ns

module exeTb import isaPkg::*, pipePkg::*; ();

    localparam int N_ALU      = 200;
    localparam int N_FWD      = 150;
    localparam int N_BRANCH   = 150;
    localparam int N_MULDIV   = 16;
    localparam int N_MOVE     = 20;
    localparam int N_FLUSH    = 8;
    localparam int MAX_CYCLES = (N_ALU + N_FWD + N_BRANCH + N_MULDIV + N_MOVE + N_FLUSH) * 40;

    logic              clk;
    logic              rst;
    logic              exeWr;
    logic              exeFlush;
    idExeBus           idIn;
    fwdSrc             memFwd;
    fwdSrc             wbFwd;
    exeMemBus          exeOut;
    branchRes          branchOut;
    logic              mulDivStall;
    logic [DATA_W-1:0] mHi;                              // model HI/LO
    logic [DATA_W-1:0] mLo;
    int                errCount;
    int                checkCount;
    int                cycles;

    `include "exeRefModel.svh"

    exeTop i_dut (
        .clk         (clk),
        .rst         (rst),
        .exeWr       (exeWr),
        .exeFlush    (exeFlush),
        .idIn        (idIn),
        .memFwd      (memFwd),
        .wbFwd       (wbFwd),
        .exeOut      (exeOut),
        .branchOut   (branchOut),
        .mulDivStall (mulDivStall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
                $display("tests failed");
                $finish;
            end
        end
    end

    task automatic checkExeMem(input string name, input exeMemBus exp, input exeMemBus act);
        checkCount++;
        if (act !== exp) begin
            errCount++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkBranch(input string name, input branchRes exp, input branchRes act);
        checkCount++;
        if (act !== exp) begin
            errCount++;
            $display("[ERROR] %s: expected taken=%b target=%h, actual taken=%b target=%h",
                     name, exp.taken, exp.target, act.taken, act.target);
        end
    endtask

    task automatic checkWord(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
        checkCount++;
        if (act !== exp) begin
            errCount++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkStall(input string name, input int exp, input int act);
        checkCount++;
        if (act != exp) begin
            errCount++;
            $display("[ERROR] %s: expected stall %0d cycles, actual %0d", name, exp, act);
        end
    endtask

    task automatic reportTest(input string name, input int err0, input int chk0);
        $display("%-8s %0d checks, %0d errors", name, checkCount - chk0, errCount - err0);
    endtask

    function automatic idExeBus randOp();
        idExeBus     op;
        logic [15:0] imm;
        op.pc      = randBits(30) << 2;
        op.busA    = randBits(32);
        op.busB    = randBits(32);
        imm        = 16'(randBits(16));
        op.imm32   = {{16{imm[15]}}, imm};
        op.rs      = 5'(randBits(5));
        op.rt      = 5'(randBits(5));
        op.dst     = 5'(randBits(5));
        op.shamt   = 5'(randBits(5));
        op.aluOp   = aluOpType'(5'(randBits(4) % 14));  // ADD..LUI only
        op.aluSrcA = 1'(randBits(1));
        op.aluSrcB = 1'(randBits(1));
        op.regWr   = randBits(2) != 0;
        op.branch  = NONE;
        return op;
    endfunction

    function automatic idExeBus fixedOp(input aluOpType aluOp);
        idExeBus op;
        op         = randOp();
        op.aluOp   = aluOp;
        op.aluSrcA = 1'b0;
        op.aluSrcB = 1'b0;
        return op;
    endfunction

    // a later stage writing rs, rt, $zero or some other register
    function automatic fwdSrc randFwd(input idExeBus op);
        fwdSrc       f;
        logic [31:0] sel;
        f.regWr  = 1'(randBits(1));
        f.result = randBits(32);
        sel      = randBits(2);
        case (sel)
            0:       f.dst = op.rs;
            1:       f.dst = op.rt;
            2:       f.dst = '0;
            default: f.dst = 5'(randBits(5));
        endcase
        return f;
    endfunction

    // load op, give it its bypass inputs, sample at the falling edge
    task automatic issue(input idExeBus op, input fwdSrc mem, input fwdSrc wb);
        @(posedge clk);
        #5;
        idIn  = op;
        exeWr = !mulDivStall;
        @(posedge clk);
        #5;
        idIn   = nopOp();                                // decode moves on
        memFwd = mem;
        wbFwd  = wb;
        exeWr  = !mulDivStall;
        @(negedge clk);
    endtask

    task automatic measureStall(output int n);
        n = 0;
        while (mulDivStall && n < MULDIV_ITER + 8) begin
            n++;
            @(posedge clk);
            #5;
            exeWr = !mulDivStall;
            @(negedge clk);
        end
    endtask

    task automatic readHiLo(input string name);
        issue(fixedOp(MFHI), '0, '0);
        checkWord($sformatf("%s hi", name), mHi, exeOut.aluOut);
        issue(fixedOp(MFLO), '0, '0);
        checkWord($sformatf("%s lo", name), mLo, exeOut.aluOut);
    endtask

    task automatic aluTest();
        idExeBus op;
        int      err0;
        int      chk0;
        err0 = errCount;
        chk0 = checkCount;
        for (int i = 0; i < N_ALU; i++) begin
            op = randOp();
            issue(op, '0, '0);
            checkExeMem($sformatf("alu %0d %s", i, op.aluOp.name()),
                        modelExe(op, '0, '0, mHi, mLo), exeOut);
        end
        reportTest("alu", err0, chk0);
    endtask

    task automatic fwdTest();
        idExeBus op;
        fwdSrc   mem;
        fwdSrc   wb;
        int      err0;
        int      chk0;
        err0 = errCount;
        chk0 = checkCount;
        for (int i = 0; i < N_FWD; i++) begin
            op = randOp();
            if (randBits(2) == 0) op.rs = '0;
            mem = randFwd(op);
            wb  = randFwd(op);
            issue(op, mem, wb);
            checkExeMem($sformatf("fwd %0d", i), modelExe(op, mem, wb, mHi, mLo), exeOut);
        end
        reportTest("forward", err0, chk0);
    endtask

    task automatic branchTest();
        idExeBus     op;
        fwdSrc       mem;
        fwdSrc       wb;
        logic [31:0] sel;
        int          err0;
        int          chk0;
        err0 = errCount;
        chk0 = checkCount;
        for (int i = 0; i < N_BRANCH; i++) begin
            op        = randOp();
            op.branch = branchType'(3'(randBits(3)));
            sel       = randBits(2);
            if (sel == 0) op.busB = op.busA;             // equal compare
            if (sel == 1) op.busA = '0;                  // zero edge of the signed tests
            mem = randFwd(op);
            wb  = randFwd(op);
            issue(op, mem, wb);
            checkBranch($sformatf("branch %0d %s", i, op.branch.name()),
                        modelBranch(op, mem, wb), branchOut);
        end
        reportTest("branch", err0, chk0);
    endtask

    task automatic mulDivTest();
        idExeBus     op;
        logic [31:0] sel;
        string       name;
        int          n;
        int          err0;
        int          chk0;
        err0 = errCount;
        chk0 = checkCount;
        for (int i = 0; i < N_MULDIV; i++) begin
            op = fixedOp(randBits(1) ? DIVU : MULTU);
            if (op.aluOp == DIVU) begin
                sel = randBits(2);
                if (sel == 0) op.busB = '0;
                if (sel == 1) op.busB = randBits(8);
            end
            if (i == 0) begin
                op.aluOp = DIVU;                         // divide by zero at least once
                op.busB  = '0;
            end
            name = $sformatf("muldiv %0d %s", i, op.aluOp.name());
            issue(op, '0, '0);
            measureStall(n);
            checkStall(name, MULDIV_ITER + 1, n);        // load cycle plus iterations
            {mHi, mLo} = modelMulDiv(op.aluOp == DIVU, op.busA, op.busB);
            readHiLo(name);
        end
        reportTest("muldiv", err0, chk0);
    endtask

    task automatic moveTest();
        idExeBus op;
        fwdSrc   mem;
        fwdSrc   wb;
        int      err0;
        int      chk0;
        err0 = errCount;
        chk0 = checkCount;
        for (int i = 0; i < N_MOVE; i++) begin
            op  = fixedOp(MTHI);
            mem = randFwd(op);
            wb  = randFwd(op);
            issue(op, mem, wb);
            mHi = fwdVal(op.rs, op.busA, mem, wb);
            op  = fixedOp(MTLO);
            mem = randFwd(op);
            wb  = randFwd(op);
            issue(op, mem, wb);
            mLo = fwdVal(op.rs, op.busA, mem, wb);
            readHiLo($sformatf("move %0d", i));
        end
        reportTest("move", err0, chk0);
    endtask

    task automatic flushTest();
        idExeBus op;
        string   name;
        int      n;
        int      k;
        int      err0;
        int      chk0;
        err0 = errCount;
        chk0 = checkCount;
        for (int i = 0; i < N_FLUSH; i++) begin
            name      = $sformatf("flush %0d", i);
            op        = fixedOp(DIVU);
            op.branch = JR;                              // taken unless flushed
            k         = int'(randBits(4));
            issue(op, '0, '0);
            repeat (k) begin
                @(posedge clk);
                #5;
                exeWr = !mulDivStall;
            end
            @(posedge clk);
            #5;
            exeFlush = 1'b1;                             // divide still running here
            exeWr    = 1'b0;
            @(posedge clk);
            #5;
            exeFlush = 1'b0;
            exeWr    = !mulDivStall;
            @(negedge clk);
            checkExeMem(name, modelExe(nopOp(), memFwd, wbFwd, mHi, mLo), exeOut);
            checkBranch(name, modelBranch(nopOp(), memFwd, wbFwd), branchOut);
            measureStall(n);
            checkStall(name, 0, n);
            repeat (MULDIV_ITER + 1) begin               // past the end of the abandoned divide
                @(posedge clk);
                #5;
                exeWr = !mulDivStall;
            end
            readHiLo(name);                              // HI/LO keep the old values
        end
        reportTest("flush", err0, chk0);
    endtask

    initial begin
        rst        = 1'b1;
        exeWr      = 1'b0;
        exeFlush   = 1'b0;
        idIn       = nopOp();
        memFwd     = '0;
        wbFwd      = '0;
        mHi        = '0;
        mLo        = '0;
        errCount   = 0;
        checkCount = 0;
        lfsr       = LFSR_SEED;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        checkExeMem("reset", modelExe(nopOp(), '0, '0, '0, '0), exeOut);
        checkBranch("reset", modelBranch(nopOp(), '0, '0), branchOut);
        checkStall("reset", 0, int'(mulDivStall));
        readHiLo("reset");                               // HI/LO cleared by reset
        aluTest();
        fwdTest();
        branchTest();
        mulDivTest();
        moveTest();
        flushTest();
        readHiLo("final");
        $display("summary: 6 tests, %0d checks, %0d mismatches", checkCount, errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+dv
hw/isaPkg.sv
hw/pipePkg.sv
hw/exeReg.sv
hw/forwardUnit.sv
hw/aluBranchUnit.sv
hw/mulDivCtrl.sv
hw/iterCounter.sv
hw/mulDivPath.sv
hw/hiLoRegs.sv
hw/exeTop.sv
dv/exeTb.sv

// File: hw/aluBranchUnit.sv
/*
 * Execute ALU with signed overflow detection, plus branch and JR resolution
 */
`timescale 1ns/1ns

module aluBranchUnit import isaPkg::*, pipePkg::*; (
    input  idExeBus           stageQ,
    input  logic [DATA_W-1:0] opA,
    input  logic [DATA_W-1:0] opB,
    input  logic [DATA_W-1:0] fwdA,
    input  logic [DATA_W-1:0] fwdB,
    input  logic [DATA_W-1:0] hi,
    input  logic [DATA_W-1:0] lo,
    output exeMemBus          exeOut,
    output branchRes          branchOut
);

    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic              addOvf;
    logic              subOvf;

    assign sum    = opA + opB;
    assign diff   = opA - opB;
    assign addOvf = (opA[DATA_W-1] == opB[DATA_W-1]) && (sum[DATA_W-1] != opA[DATA_W-1]);
    assign subOvf = (opA[DATA_W-1] != opB[DATA_W-1]) && (diff[DATA_W-1] != opA[DATA_W-1]);

    always_comb begin
        unique case (stageQ.aluOp)
            ADD, ADDU: exeOut.aluOut = sum;
            SUB, SUBU: exeOut.aluOut = diff;
            AND:       exeOut.aluOut = opA & opB;
            OR:        exeOut.aluOut = opA | opB;
            XOR:       exeOut.aluOut = opA ^ opB;
            NOR:       exeOut.aluOut = ~(opA | opB);
            SLT:       exeOut.aluOut = DATA_W'($signed(opA) < $signed(opB));
            SLTU:      exeOut.aluOut = DATA_W'(opA < opB);
            SLL:       exeOut.aluOut = opB << opA[4:0];  // amount from shamt or rs
            SRL:       exeOut.aluOut = opB >> opA[4:0];
            SRA:       exeOut.aluOut = $signed(opB) >>> opA[4:0];
            LUI:       exeOut.aluOut = {opB[15:0], 16'b0};
            MFHI:      exeOut.aluOut = hi;
            MFLO:      exeOut.aluOut = lo;
            default:   exeOut.aluOut = '0;               // mt*, mul/div write no GPR
        endcase
        exeOut.excOverflow = (stageQ.aluOp == ADD && addOvf) ||
                             (stageQ.aluOp == SUB && subOvf);
        exeOut.regWr       = stageQ.regWr && !exeOut.excOverflow;
        exeOut.storeData   = fwdB;
        exeOut.dst         = stageQ.dst;
    end

    always_comb begin
        unique case (stageQ.branch)
            BEQ:     branchOut.taken = (fwdA == fwdB);
            BNE:     branchOut.taken = (fwdA != fwdB);
            BLEZ:    branchOut.taken = fwdA[DATA_W-1] || (fwdA == '0);
            BGTZ:    branchOut.taken = !fwdA[DATA_W-1] && (fwdA != '0);
            BLTZ:    branchOut.taken = fwdA[DATA_W-1];
            BGEZ:    branchOut.taken = !fwdA[DATA_W-1];
            JR:      branchOut.taken = 1'b1;
            default: branchOut.taken = 1'b0;
        endcase
        if (stageQ.branch == JR) begin
            branchOut.target = fwdA;
        end else begin
            branchOut.target = stageQ.pc + DATA_W'(4) + {stageQ.imm32[DATA_W-3:0], 2'b00};
        end
    end

    ovfOnlyAddSub: assert final (!exeOut.excOverflow || stageQ.aluOp inside {ADD, SUB});

endmodule

// File: hw/exeReg.sv
/*
 * ID/EXE stage register, loads a bubble on flush
 */
`timescale 1ns/1ns

module exeReg import pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    exeWr,
    input  logic    exeFlush,
    input  idExeBus idIn,
    output idExeBus stageQ
);

    always_ff @(posedge clk) begin
        if (rst) begin
            stageQ <= BUBBLE;
        end else if (exeFlush) begin
            stageQ <= BUBBLE;                            // flush beats write enable
        end else if (exeWr) begin
            stageQ <= idIn;
        end
    end

endmodule

// File: hw/exeTop.sv
/*
 * Execute stage: stage register, bypass, ALU/branch and the mul/div unit
 */
`timescale 1ns/1ns

module exeTop import isaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     exeWr,
    input  logic     exeFlush,
    input  idExeBus  idIn,
    input  fwdSrc    memFwd,
    input  fwdSrc    wbFwd,
    output exeMemBus exeOut,
    output branchRes branchOut,
    output logic     mulDivStall
);

    idExeBus           stageQ;
    logic [DATA_W-1:0] fwdA;
    logic [DATA_W-1:0] fwdB;
    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opB;
    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] lo;
    logic [DATA_W-1:0] hiRes;
    logic [DATA_W-1:0] loRes;
    logic              load;
    logic              done;
    logic              hiLoLoad;

    exeReg u_exeReg (
        .clk      (clk),
        .rst      (rst),
        .exeWr    (exeWr),
        .exeFlush (exeFlush),
        .idIn     (idIn),
        .stageQ   (stageQ)
    );

    forwardUnit u_forwardUnit (
        .stageQ (stageQ),
        .memFwd (memFwd),
        .wbFwd  (wbFwd),
        .fwdA   (fwdA),
        .fwdB   (fwdB),
        .opA    (opA),
        .opB    (opB)
    );

    aluBranchUnit u_aluBranchUnit (
        .stageQ    (stageQ),
        .opA       (opA),
        .opB       (opB),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .hi        (hi),
        .lo        (lo),
        .exeOut    (exeOut),
        .branchOut (branchOut)
    );

    mulDivCtrl u_mulDivCtrl (
        .clk         (clk),
        .rst         (rst),
        .exeWr       (exeWr),
        .exeFlush    (exeFlush),
        .aluOp       (stageQ.aluOp),
        .done        (done),
        .load        (load),
        .mulDivStall (mulDivStall),
        .hiLoLoad    (hiLoLoad)
    );

    iterCounter u_iterCounter (
        .clk   (clk),
        .rst   (rst),
        .load  (load),
        .clear (exeFlush),
        .done  (done)
    );

    mulDivPath u_mulDivPath (
        .clk   (clk),
        .load  (load),
        .isDiv (stageQ.aluOp == DIVU),
        .a     (fwdA),
        .b     (fwdB),
        .hiRes (hiRes),
        .loRes (loRes)
    );

    hiLoRegs u_hiLoRegs (
        .clk      (clk),
        .rst      (rst),
        .hiLoLoad (hiLoLoad),
        .hiRes    (hiRes),
        .loRes    (loRes),
        .aluOp    (stageQ.aluOp),
        .wrData   (fwdA),                                // mthi/mtlo source is rs
        .exeFlush (exeFlush),
        .hi       (hi),
        .lo       (lo)
    );

endmodule

// File: hw/forwardUnit.sv
/*
 * Operand bypass from MEM and WB, then shamt/immediate selection
 */
`timescale 1ns/1ns

module forwardUnit import isaPkg::*, pipePkg::*; (
    input  idExeBus           stageQ,
    input  fwdSrc             memFwd,
    input  fwdSrc             wbFwd,
    output logic [DATA_W-1:0] fwdA,
    output logic [DATA_W-1:0] fwdB,
    output logic [DATA_W-1:0] opA,
    output logic [DATA_W-1:0] opB
);

    function automatic logic [DATA_W-1:0] bypass(
        input logic [REG_W-1:0]  src,
        input logic [DATA_W-1:0] rfVal,
        input fwdSrc             mem,
        input fwdSrc             wb
    );
        logic [DATA_W-1:0] val;
        val = rfVal;
        if (src != '0) begin                             // $zero is never bypassed
            if (mem.regWr && mem.dst == src) begin
                val = mem.result;                        // younger result wins
            end else if (wb.regWr && wb.dst == src) begin
                val = wb.result;
            end
        end
        return val;
    endfunction

    assign fwdA = bypass(stageQ.rs, stageQ.busA, memFwd, wbFwd);
    assign fwdB = bypass(stageQ.rt, stageQ.busB, memFwd, wbFwd);

    assign opA = stageQ.aluSrcA ? {{(DATA_W-REG_W){1'b0}}, stageQ.shamt} : fwdA;
    assign opB = stageQ.aluSrcB ? stageQ.imm32 : fwdB;

endmodule

// File: hw/hiLoRegs.sv
/*
 * HI/LO registers, loaded by mul/div completion or by MTHI/MTLO
 */
`timescale 1ns/1ns

module hiLoRegs import isaPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              hiLoLoad,
    input  logic [DATA_W-1:0] hiRes,
    input  logic [DATA_W-1:0] loRes,
    input  aluOpType          aluOp,
    input  logic [DATA_W-1:0] wrData,
    input  logic              exeFlush,
    output logic [DATA_W-1:0] hi,
    output logic [DATA_W-1:0] lo
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (hiLoLoad) begin
            hi <= hiRes;
            lo <= loRes;
        end else if (!exeFlush) begin                    // flushed move is dropped
            if (aluOp == MTHI) hi <= wrData;
            if (aluOp == MTLO) lo <= wrData;
        end
    end

    noLoadDuringMove: assert property (@(posedge clk) disable iff (rst)
        hiLoLoad |-> !(aluOp inside {MTHI, MTLO}));

endmodule

// File: hw/isaPkg.sv
/*
 * ISA encodings for the execute stage: ALU operations, branch kinds
 * and the datapath constants shared by the whole pipeline.
 */
package isaPkg;

    localparam int DATA_W      = 32;
    localparam int REG_W       = 5;
    localparam int MULDIV_ITER = 32;                     // one quotient/product bit per cycle
    localparam int CNT_W       = $clog2(MULDIV_ITER + 1);

    typedef enum logic [4:0] {
        ADD   = 5'd0,                                    // traps on signed overflow
        ADDU  = 5'd1,
        SUB   = 5'd2,                                    // traps on signed overflow
        SUBU  = 5'd3,
        AND   = 5'd4,
        OR    = 5'd5,
        XOR   = 5'd6,
        NOR   = 5'd7,
        SLT   = 5'd8,
        SLTU  = 5'd9,
        SLL   = 5'd10,
        SRL   = 5'd11,
        SRA   = 5'd12,
        LUI   = 5'd13,
        MFHI  = 5'd14,
        MFLO  = 5'd15,
        MTHI  = 5'd16,
        MTLO  = 5'd17,
        MULTU = 5'd18,                                   // unsigned only
        DIVU  = 5'd19
    } aluOpType;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        BEQ  = 3'd1,
        BNE  = 3'd2,
        BLEZ = 3'd3,
        BGTZ = 3'd4,
        BLTZ = 3'd5,
        BGEZ = 3'd6,
        JR   = 3'd7                                      // target comes from rs
    } branchType;

endpackage

// File: hw/iterCounter.sv
/*
 * Iteration counter for mul/div, done one cycle before it empties
 */
`timescale 1ns/1ns

module iterCounter import isaPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic clear,
    output logic done
);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= CNT_W'(MULDIV_ITER);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign done = (cnt == CNT_W'(1));                    // last iteration cycle

    doneAfterLoad: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(load, MULDIV_ITER));

endmodule

// File: hw/mulDivCtrl.sv
/*
 * Sequencer for the iterative MULTU/DIVU unit, raises the pipeline stall
 */
`timescale 1ns/1ns

module mulDivCtrl import isaPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     exeWr,
    input  logic     exeFlush,
    input  aluOpType aluOp,
    input  logic     done,
    output logic     load,
    output logic     mulDivStall,
    output logic     hiLoLoad
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} stateType;

    stateType state;
    stateType stateNext;
    logic     isMulDiv;

    assign isMulDiv = (aluOp == MULTU) || (aluOp == DIVU);

    always_comb begin
        stateNext = state;
        unique case (state)
            IDLE: if (isMulDiv && !exeFlush) stateNext = RUN;
            RUN: begin
                if (exeFlush) begin
                    stateNext = IDLE;                    // abandon, HI/LO untouched
                end else if (done) begin
                    stateNext = DONE;
                end
            end
            DONE: if (exeWr || exeFlush) stateNext = IDLE; // wait for a new op
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    assign load        = (state == IDLE) && isMulDiv && !exeFlush;
    assign mulDivStall = ((state == IDLE) && isMulDiv) || (state == RUN);
    assign hiLoLoad    = (state == RUN) && done && !exeFlush;

    loadStartsRun: assert property (@(posedge clk) disable iff (rst)
        load |-> (state == IDLE) ##1 (state == RUN));

    noStallInDone: assert property (@(posedge clk) disable iff (rst)
        (state == DONE) |-> !mulDivStall);

endmodule

// File: hw/mulDivPath.sv
/*
 * Unsigned shift-add multiplier and restoring divider, one bit per cycle.
 * hiRes/loRes show the accumulators after the current step.
 */
`timescale 1ns/1ns

module mulDivPath import isaPkg::*; (
    input  logic              clk,
    input  logic              load,
    input  logic              isDiv,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] hiRes,
    output logic [DATA_W-1:0] loRes
);

    logic [DATA_W-1:0] hiQ;                              // partial product / remainder
    logic [DATA_W-1:0] loQ;                              // multiplier / quotient
    logic [DATA_W-1:0] opQ;                              // multiplicand / divisor
    logic [DATA_W:0]   addSum;
    logic [DATA_W:0]   shifted;
    logic [DATA_W:0]   trial;

    always_comb begin
        addSum  = {1'b0, hiQ} + (loQ[0] ? {1'b0, opQ} : '0);
        shifted = {hiQ, loQ[DATA_W-1]};
        trial   = shifted - {1'b0, opQ};
        if (isDiv) begin
            // borrow means restore; a zero divisor never borrows
            hiRes = trial[DATA_W] ? shifted[DATA_W-1:0] : trial[DATA_W-1:0];
            loRes = {loQ[DATA_W-2:0], ~trial[DATA_W]};
        end else begin
            hiRes = addSum[DATA_W:1];
            loRes = {addSum[0], loQ[DATA_W-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hiQ <= '0;
            loQ <= isDiv ? a : b;                        // dividend or multiplier
            opQ <= isDiv ? b : a;
        end else begin
            hiQ <= hiRes;
            loQ <= loRes;
        end
    end

endmodule

// File: hw/pipePkg.sv
/*
 * Pipeline buses around the execute stage: the decoded instruction
 * coming in, the forwarding ports and the results going out.
 */
package pipePkg;

    import isaPkg::*;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] busA;                         // rs read
        logic [DATA_W-1:0] busB;                         // rt read
        logic [DATA_W-1:0] imm32;
        logic [REG_W-1:0]  rs;
        logic [REG_W-1:0]  rt;
        logic [REG_W-1:0]  dst;
        logic [REG_W-1:0]  shamt;
        aluOpType          aluOp;
        logic              aluSrcA;                      // use shamt for A
        logic              aluSrcB;                      // use imm32 for B
        logic              regWr;
        branchType         branch;
    } idExeBus;

    typedef struct packed {
        logic              regWr;
        logic [REG_W-1:0]  dst;
        logic [DATA_W-1:0] result;
    } fwdSrc;

    typedef struct packed {
        logic [DATA_W-1:0] aluOut;
        logic [DATA_W-1:0] storeData;
        logic [REG_W-1:0]  dst;
        logic              regWr;
        logic              excOverflow;
    } exeMemBus;

    typedef struct packed {
        logic              taken;
        logic [DATA_W-1:0] target;
    } branchRes;

    // nop held by the stage after reset or flush
    localparam idExeBus BUBBLE = '{aluOp: ADDU, branch: NONE, default: '0};

endpackage
